/* ll_link_input.txt */
// Header: delay_x, delay_y, init_credit, data word count
// Then the data words, the stall count and the tready stall lengths in cycles
00000005
00000003
00000004
0000000c
// Data words, sent on M2S and expected back on S2M in this order
1234abcd
deadbeef
00000001
ffffffff
a5a5a5a5
5a5a5a5a
80000000
0badf00d
13579bdf
2468ace0
7fffffff
c0ffee00
// Stall count, then the stall lengths
00000003
00000003
00000014
00000002

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= ll_link_tb
FILELIST ?= ll_link_top.f
OBJ_DIR  ?= obj_dir

SRCS := $(shell grep -v '^+' $(FILELIST)) ll_params.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "^TESTS PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* ll_link_top.f */
+incdir+.
ll_pkg.sv
ll_auto_sync.sv
ll_transmit.sv
ll_receive.sv
ll_phy_concat.sv
ll_link_top.sv
ll_link_tb.sv

/* ll_link_tb.sv */
`timescale 1ns/1ps

module ll_link_tb import ll_pkg::*; ();

  localparam int TIMEOUT = 200;

  logic           clk_wr;
  logic           rst;
  logic           tx_online;
  logic           rx_online;
  ll_credit_cnt_t init_credit;
  ll_delay_t      delay_x_value;
  ll_delay_t      delay_y_value;
  ll_data_t       user_m2s_tdata;
  logic           user_m2s_tvalid;
  logic           user_m2s_tready;
  ll_data_t       user_s2m_tdata;
  logic           user_s2m_tvalid;
  logic           user_s2m_tready;
  ll_phy_t        tx_phy;
  ll_phy_t        rx_phy;
  logic [31:0]    tx_debug_status;
  logic [31:0]    rx_debug_status;

  logic [31:0]    stim [0:63];
  int             delay_x;
  int             delay_y;
  int             credit_init;
  int             n_words;
  int             n_stalls;
  int             seed;
  int             pushes;
  int             returned;
  int             waited;
  int             idle;

  ll_link_top uut (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .init_credit     (init_credit),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .user_m2s_tdata  (user_m2s_tdata),
    .user_m2s_tvalid (user_m2s_tvalid),
    .user_m2s_tready (user_m2s_tready),
    .user_s2m_tdata  (user_s2m_tdata),
    .user_s2m_tvalid (user_s2m_tvalid),
    .user_s2m_tready (user_s2m_tready),
    .tx_phy          (tx_phy),
    .rx_phy          (rx_phy),
    .tx_debug_status (tx_debug_status),
    .rx_debug_status (rx_debug_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  // PHY loopback through one register stage
  always @(posedge clk_wr) begin
    if (rst) begin
      rx_phy <= '0;
    end else begin
      rx_phy <= tx_phy;
    end
  end

  //////////////////////////////////////////////////
  // Helpers

  task automatic check_value(input string name, input logic [39:0] actual,
                             input logic [39:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s actual=0x%0h expected=0x%0h", name, actual, expected);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out while waiting for %s", what);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  // Pushes on the lane never outrun the credit handed out
  always @(negedge clk_wr) begin
    if (!rst && tx_online) begin
      pushes   = pushes + int'(tx_phy[32]);
      returned = returned + int'(tx_phy[36:33]);
      check_value("tx_phy_pad", 40'(tx_phy[39:37]), 40'h0);
      check_value("push_within_credit", 40'(pushes <= credit_init + returned), 40'h1);
    end
  end

  task automatic send_words();
    int gap;
    int wait_cnt;
    for (int i = 0; i < n_words; i++) begin
      gap = $random(seed) & 32'h3;
      user_m2s_tvalid = 1'b0;
      repeat (gap) @(negedge clk_wr);
      user_m2s_tvalid = 1'b1;
      user_m2s_tdata  = stim[4 + i];
      wait_cnt = 0;
      while (!user_m2s_tready) begin
        @(negedge clk_wr);
        wait_cnt++;
        if (wait_cnt > TIMEOUT) report_timeout("user_m2s_tready");
      end
      // Beat transfers on the next rising edge
      @(negedge clk_wr);
    end
    user_m2s_tvalid = 1'b0;
  endtask

  task automatic receive_words();
    int       stall_idx;
    int       wait_cnt;
    logic     held;
    ll_data_t held_data;
    stall_idx = 0;
    for (int i = 0; i < n_words; i++) begin
      if (stall_idx < n_stalls && i == 2 + 4 * stall_idx) begin
        user_s2m_tready = 1'b0;
        held = 1'b0;
        repeat (int'(stim[5 + n_words + stall_idx])) begin
          @(negedge clk_wr);
          if (held) begin
            check_value("user_s2m_tvalid", 40'(user_s2m_tvalid), 40'h1);
            check_value("user_s2m_tdata", 40'(user_s2m_tdata), 40'(held_data));
          end
          if (user_s2m_tvalid) begin
            held      = 1'b1;
            held_data = user_s2m_tdata;
          end
        end
        stall_idx++;
      end
      user_s2m_tready = 1'b1;
      wait_cnt = 0;
      while (!user_s2m_tvalid) begin
        @(negedge clk_wr);
        wait_cnt++;
        if (wait_cnt > TIMEOUT) report_timeout("user_s2m_tvalid");
      end
      check_value("user_s2m_tdata", 40'(user_s2m_tdata), 40'(stim[4 + i]));
      @(negedge clk_wr);
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence

  initial begin
    rst             = 1'b1;
    tx_online       = 1'b0;
    rx_online       = 1'b0;
    init_credit     = '0;
    delay_x_value   = '0;
    delay_y_value   = '0;
    user_m2s_tdata  = '0;
    user_m2s_tvalid = 1'b0;
    user_s2m_tready = 1'b0;
    rx_phy          = '0;
    seed            = 32'hc298;
    pushes          = 0;
    returned        = 0;

    $readmemh("ll_link_input.txt", stim);
    delay_x     = int'(stim[0]);
    delay_y     = int'(stim[1]);
    credit_init = int'(stim[2]);
    n_words     = int'(stim[3]);
    n_stalls    = int'(stim[4 + n_words]);

    delay_x_value = ll_delay_t'(stim[0]);
    delay_y_value = ll_delay_t'(stim[1]);
    init_credit   = ll_credit_cnt_t'(stim[2]);

    repeat (16) @(negedge clk_wr);
    rst = 1'b0;
    @(negedge clk_wr);

    // Quiet outputs before bring-up
    check_value("tx_phy", 40'(tx_phy), 40'h0);
    check_value("user_m2s_tready", 40'(user_m2s_tready), 40'h0);
    check_value("user_s2m_tvalid", 40'(user_s2m_tvalid), 40'h0);
    check_value("tx_debug_status", 40'(tx_debug_status), 40'h0);
    check_value("rx_debug_status", 40'(rx_debug_status), 40'h0);

    // First word waits on M2S through bring-up
    user_m2s_tdata  = stim[4];
    user_m2s_tvalid = 1'b1;
    tx_online = 1'b1;
    rx_online = 1'b1;
    waited = 0;
    while (!user_m2s_tready) begin
      @(negedge clk_wr);
      waited++;
      check_value("tx_phy_pushbit", 40'(tx_phy[32]), 40'h0);
      if (waited > TIMEOUT) report_timeout("link bring-up");
    end
    check_value("bring_up_delay_ok", 40'(waited >= delay_x + delay_y), 40'h1);

    fork
      send_words();
      receive_words();
    join

    // Idle means no push, no credit in flight, nothing queued
    idle = 0;
    waited = 0;
    while (idle < 3) begin
      @(negedge clk_wr);
      waited++;
      if (tx_phy == '0 && rx_phy == '0 && !user_s2m_tvalid) begin
        idle++;
      end else begin
        idle = 0;
      end
      if (waited > TIMEOUT) report_timeout("idle link");
    end

    check_value("tx_debug_sent", 40'(tx_debug_status[15:0]), 40'(n_words));
    check_value("rx_debug_recv", 40'(rx_debug_status[15:0]), 40'(n_words));
    check_value("tx_debug_credit", 40'(tx_debug_status[23:16]), 40'(credit_init));
    check_value("rx_debug_count", 40'(rx_debug_status[23:16]), 40'h0);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* ll_link_top.sv */
`timescale 1ns/1ps
`include "ll_params.svh"

module ll_link_top import ll_pkg::*; (
  input  logic           clk_wr,
  input  logic           rst,

  // Link control
  input  logic           tx_online,
  input  logic           rx_online,
  input  ll_credit_cnt_t init_credit,
  input  ll_delay_t      delay_x_value,
  input  ll_delay_t      delay_y_value,

  // M2S stream
  input  ll_data_t       user_m2s_tdata,
  input  logic           user_m2s_tvalid,
  output logic           user_m2s_tready,

  // S2M stream
  output ll_data_t       user_s2m_tdata,
  output logic           user_s2m_tvalid,
  input  logic           user_s2m_tready,

  // PHY lane
  output ll_phy_t        tx_phy,
  input  ll_phy_t        rx_phy,

  output logic [31:0]    tx_debug_status,
  output logic [31:0]    rx_debug_status
);

  logic     tx_online_delay;
  logic     rx_online_delay;
  ll_push_t tx_push;
  ll_push_t rx_push;
  ll_cred_t tx_credit;
  ll_cred_t rx_credit;

  //////////////////////////////////////////////////
  // Bring-up

  ll_auto_sync ll_auto_sync_i (
    .clk_wr          (clk_wr),
    .rst             (rst),
    .tx_online       (tx_online),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .delay_y_value   (delay_y_value),
    .tx_online_delay (tx_online_delay),
    .rx_online_delay (rx_online_delay)
  );

  //////////////////////////////////////////////////
  // Transmit and receive engines

  ll_transmit ll_transmit_i (
    .clk_wr       (clk_wr),
    .rst          (rst),
    .tx_online    (tx_online_delay),
    .rx_online    (rx_online_delay),
    .init_credit  (init_credit),
    .user_data    (user_m2s_tdata),
    .user_valid   (user_m2s_tvalid),
    .user_ready   (user_m2s_tready),
    .tx_push      (tx_push),
    .rx_credit    (rx_credit),
    .debug_status (tx_debug_status)
  );

  ll_receive ll_receive_i (
    .clk_wr       (clk_wr),
    .rst          (rst),
    .rx_online    (rx_online_delay),
    .rx_push      (rx_push),
    .user_data    (user_s2m_tdata),
    .user_valid   (user_s2m_tvalid),
    .user_ready   (user_s2m_tready),
    .tx_credit    (tx_credit),
    .debug_status (rx_debug_status)
  );

  //////////////////////////////////////////////////
  // Lane packer

  ll_phy_concat ll_phy_concat_i (
    .clk_wr    (clk_wr),
    .rst       (rst),
    .tx_push   (tx_push),
    .tx_credit (tx_credit),
    .tx_phy    (tx_phy),
    .rx_phy    (rx_phy),
    .rx_push   (rx_push),
    .rx_credit (rx_credit)
  );

endmodule

/* ll_phy_concat.sv */
`timescale 1ns/1ps
`include "ll_params.svh"

module ll_phy_concat import ll_pkg::*; (
  input  logic     clk_wr,
  input  logic     rst,

  // Transmit side results
  input  ll_push_t tx_push,
  input  ll_cred_t tx_credit,
  output ll_phy_t  tx_phy,

  // Received lane
  input  ll_phy_t  rx_phy,
  output ll_push_t rx_push,
  output ll_cred_t rx_credit
);

  localparam int PUSH_W = $bits(ll_push_t);
  localparam int PAD_W  = `LL_PHY_W - PUSH_W - `LL_CRED_W;

  ll_push_t lane_push;

  //////////////////////////////////////////////////
  // Pack

  // Idle lane carries zero data
  always_comb begin
    lane_push = tx_push;
    if (!tx_push.pushbit) begin
      lane_push.data = '0;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_phy <= '0;
    end else begin
      tx_phy <= {{PAD_W{1'b0}}, tx_credit, lane_push};
    end
  end

  //////////////////////////////////////////////////
  // Unpack

  // Top pad bits are ignored
  assign rx_push   = ll_push_t'(rx_phy[PUSH_W-1:0]);
  assign rx_credit = rx_phy[PUSH_W +: `LL_CRED_W];

endmodule

/* ll_receive.sv */
`timescale 1ns/1ps
`include "ll_params.svh"

module ll_receive import ll_pkg::*; (
  input  logic        clk_wr,
  input  logic        rst,
  input  logic        rx_online,

  // From the PHY unpacker
  input  ll_push_t    rx_push,

  // User side
  output ll_data_t    user_data,
  output logic        user_valid,
  input  logic        user_ready,

  // Credit back to the far transmitter
  output ll_cred_t    tx_credit,

  output logic [31:0] debug_status
);

  localparam int DEPTH = `LL_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = AW + 1;

  ll_data_t             mem [DEPTH];
  logic [AW-1:0]        wr_ptr;
  logic [AW-1:0]        rd_ptr;
  logic [CW-1:0]        count;
  logic                 full;
  logic                 push;
  logic                 pop;
  logic [`LL_CNT_W-1:0] recv_cnt;

  //////////////////////////////////////////////////
  // Receive FIFO

  assign full       = (count == CW'(DEPTH));
  assign push       = rx_online && rx_push.pushbit;
  assign user_valid = (count != '0);
  assign pop        = user_valid && user_ready;

  // Head word stays put until popped
  assign user_data = mem[rd_ptr];

  always_ff @(posedge clk_wr) begin
    if (push && !full) begin
      mem[wr_ptr] <= rx_push.data;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push && !full) begin
        wr_ptr <= wr_ptr + AW'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
      count <= count + CW'(push && !full) - CW'(pop);
    end
  end

  //////////////////////////////////////////////////
  // Credit return and debug

  // One credit per popped word, a cycle later
  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_credit <= '0;
      recv_cnt  <= '0;
    end else begin
      tx_credit <= ll_cred_t'(pop);
      if (push) begin
        recv_cnt <= recv_cnt + 1'b1;
      end
    end
  end

  assign debug_status = {8'h00, {(8 - CW){1'b0}}, count, recv_cnt};

  // Far side credit accounting keeps us from overflowing
  a_no_overflow: assert property (
    @(posedge clk_wr) disable iff (rst)
    push |-> !full
  );

endmodule

/* ll_transmit.sv */
`timescale 1ns/1ps
`include "ll_params.svh"

module ll_transmit import ll_pkg::*; (
  input  logic           clk_wr,
  input  logic           rst,

  // Delayed link status
  input  logic           tx_online,
  input  logic           rx_online,
  input  ll_credit_cnt_t init_credit,

  // User side
  input  ll_data_t       user_data,
  input  logic           user_valid,
  output logic           user_ready,

  // PHY side
  output ll_push_t       tx_push,
  input  ll_cred_t       rx_credit,

  output logic [31:0]    debug_status
);

  localparam int DEPTH = `LL_FIFO_DEPTH;
  localparam int AW    = $clog2(DEPTH);
  localparam int CW    = AW + 1;

  ll_data_t              mem [DEPTH];
  logic [AW-1:0]         wr_ptr;
  logic [AW-1:0]         rd_ptr;
  logic [CW-1:0]         count;
  logic                  full;
  logic                  empty;
  logic                  wr_en;
  logic                  pop;

  logic                  link_up;
  logic                  link_up_q;
  ll_credit_cnt_t        credit;
  logic [`LL_CNT_W-1:0]  sent_cnt;

  //////////////////////////////////////////////////
  // FIFO status and handshakes

  assign link_up    = tx_online && rx_online;
  assign full       = (count == CW'(DEPTH));
  assign empty      = (count == '0);
  assign user_ready = link_up && !full;
  assign wr_en      = user_valid && user_ready;

  // Credit of zero also covers the offline case
  assign pop = link_up && !empty && (credit != '0);

  // Storage
  always_ff @(posedge clk_wr) begin
    if (wr_en) begin
      mem[wr_ptr] <= user_data;
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + AW'(1);
      end
      if (pop) begin
        rd_ptr <= rd_ptr + AW'(1);
      end
      count <= count + CW'(wr_en) - CW'(pop);
    end
  end

  //////////////////////////////////////////////////
  // Credit counter

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      link_up_q <= 1'b0;
      credit    <= '0;
    end else begin
      link_up_q <= link_up;
      if (!link_up) begin
        credit <= '0;
      end else if (!link_up_q) begin
        // Fresh link gets the programmed credit
        credit <= init_credit;
      end else begin
        credit <= credit + ll_credit_cnt_t'(rx_credit) - ll_credit_cnt_t'(pop);
      end
    end
  end

  //////////////////////////////////////////////////
  // Push register and debug

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      tx_push.pushbit <= 1'b0;
    end else begin
      tx_push.pushbit <= pop;
    end
  end

  // Data word only moves on a pop
  always_ff @(posedge clk_wr) begin
    if (pop) begin
      tx_push.data <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      sent_cnt <= '0;
    end else if (pop) begin
      sent_cnt <= sent_cnt + 1'b1;
    end
  end

  assign debug_status = {8'h00, credit, sent_cnt};

  // Returned credit never outgrows what was handed out
  a_credit_bound: assert property (
    @(posedge clk_wr) disable iff (rst)
    credit <= init_credit
  );

endmodule

/* ll_auto_sync.sv */
`timescale 1ns/1ps
`include "ll_params.svh"

module ll_auto_sync import ll_pkg::*; (
  input  logic      clk_wr,
  input  logic      rst,

  // Raw link status
  input  logic      tx_online,
  input  logic      rx_online,

  // Programmed bring-up delays
  input  ll_delay_t delay_x_value,
  input  ll_delay_t delay_y_value,

  // Delayed link status
  output logic      tx_online_delay,
  output logic      rx_online_delay
);

  ll_sync_state_e state;
  ll_delay_t      cnt;

  //////////////////////////////////////////////////
  // Bring-up sequence

  always_ff @(posedge clk_wr) begin
    if (rst) begin
      state <= SYNC_OFFLINE;
      cnt   <= '0;
    end else if (!tx_online) begin
      // Losing tx drops the whole link at once
      state <= SYNC_OFFLINE;
      cnt   <= '0;
    end else begin
      case (state)
        SYNC_OFFLINE: begin
          if (delay_x_value == '0) begin
            state <= SYNC_RX_WAIT;
            cnt   <= delay_y_value;
          end else begin
            state <= SYNC_TX_WAIT;
            cnt   <= delay_x_value - ll_delay_t'(1);
          end
        end
        SYNC_TX_WAIT: begin
          if (cnt == '0) begin
            state <= SYNC_RX_WAIT;
            cnt   <= delay_y_value;
          end else begin
            cnt <= cnt - ll_delay_t'(1);
          end
        end
        SYNC_RX_WAIT: begin
          // Count only runs while the far side is up
          if (!rx_online) begin
            cnt <= delay_y_value;
          end else if (cnt == '0) begin
            state <= SYNC_ONLINE;
          end else begin
            cnt <= cnt - ll_delay_t'(1);
          end
        end
        SYNC_ONLINE: begin
          if (!rx_online) begin
            state <= SYNC_RX_WAIT;
            cnt   <= delay_y_value;
          end
        end
        default: begin
          state <= SYNC_OFFLINE;
        end
      endcase
    end
  end

  // Outputs decoded from state
  assign tx_online_delay = (state == SYNC_RX_WAIT) || (state == SYNC_ONLINE);
  assign rx_online_delay = (state == SYNC_ONLINE);

endmodule

/* ll_pkg.sv */
`include "ll_params.svh"

package ll_pkg;

  //////////////////////////////////////////////////
  // Vector types

  typedef logic [`LL_DATA_W-1:0] ll_data_t;
  typedef logic [`LL_PHY_W-1:0]  ll_phy_t;
  typedef logic [`LL_CRED_W-1:0] ll_cred_t;
  typedef logic [7:0]            ll_credit_cnt_t;
  typedef logic [`LL_CNT_W-1:0]  ll_delay_t;

  //////////////////////////////////////////////////
  // Push word, pushbit sits above the data

  typedef struct packed {
    logic     pushbit;
    ll_data_t data;
  } ll_push_t;

  //////////////////////////////////////////////////
  // Link bring-up

  typedef enum logic [1:0] {
    SYNC_OFFLINE,
    SYNC_TX_WAIT,
    SYNC_RX_WAIT,
    SYNC_ONLINE
  } ll_sync_state_e;

endpackage

/* ll_params.svh */
`ifndef LL_PARAMS_SVH
`define LL_PARAMS_SVH

// User data width
`define LL_DATA_W     32

// Entries in each FIFO
`define LL_FIFO_DEPTH 8

// One PHY lane
`define LL_PHY_W      40

// Credit return field in the lane word
`define LL_CRED_W     4

// Delay and debug counters
`define LL_CNT_W      16

`endif
